//--- hw/fix_pkg.sv
package fix_pkg;

	// ##############################
	// sizes
	// ##############################

	localparam int TAG_BYTES = 4;
	localparam int VAL_BYTES = 32;
	localparam int TAG_LEN_W = 3;
	localparam int VAL_LEN_W = 6;

	// byte index widths inside the tag and value words
	localparam int TAG_IDX_W = $clog2(TAG_BYTES);
	localparam int VAL_IDX_W = $clog2(VAL_BYTES);

	localparam int MSG_LEN_W = 16;
	localparam int DIGITS_W = 24;

	// "10=" + three digits + SOH
	localparam int TRAILER_LEN = 7;

	// ##############################
	// ascii
	// ##############################

	localparam logic [7:0] ASCII_EQ = 8'h3d;
	localparam logic [7:0] ASCII_SOH = 8'h01;
	localparam logic [7:0] ASCII_ZERO = 8'h30;
	localparam logic [7:0] CKSUM_TAG0 = 8'h31;
	localparam logic [7:0] CKSUM_TAG1 = 8'h30;

	// one tag/value pair, bytes lowest first
	typedef struct packed {
		logic [TAG_BYTES*8-1:0] tag;
		logic [TAG_LEN_W-1:0]   tag_len;
		logic [VAL_BYTES*8-1:0] val;
		logic [VAL_LEN_W-1:0]   val_len;
	} fix_field_t;

	typedef struct packed {
		logic [7:0] data;
		logic       field_last;
		logic       msg_last;
	} fix_beat_t;

endpackage

//--- hw/fix_field_capture.sv
`timescale 1ns/1ps

module fix_field_capture (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              tag_valid_i,
	input  logic [fix_pkg::TAG_BYTES*8-1:0]   tag_i,
	input  logic [fix_pkg::TAG_LEN_W-1:0]     tag_len_i,
	input  logic                              val_valid_i,
	input  logic [fix_pkg::VAL_BYTES*8-1:0]   val_i,
	input  logic [fix_pkg::VAL_LEN_W-1:0]     val_len_i,
	input  logic                              end_msg_i,
	input  logic                              busy_i,
	input  logic                              take_i,
	output fix_pkg::fix_field_t               field_o,
	output logic                              field_req_o,
	output logic                              end_req_o
);

	logic tag_seen;
	logic val_seen;
	logic accept;

	// busy also covers a pending request, so a held field cannot be overwritten
	assign accept = !busy_i && !take_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			tag_seen <= 1'b0;
			val_seen <= 1'b0;
			end_req_o <= 1'b0;
		end else if (take_i) begin
			tag_seen <= 1'b0;
			val_seen <= 1'b0;
			end_req_o <= 1'b0;
		end else if (accept) begin
			if (end_msg_i) begin
				// end drops any half field
				tag_seen <= 1'b0;
				val_seen <= 1'b0;
				end_req_o <= 1'b1;
			end else begin
				if (tag_valid_i)
					tag_seen <= 1'b1;
				if (val_valid_i)
					val_seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !end_msg_i) begin
			if (tag_valid_i) begin
				field_o.tag <= tag_i;
				field_o.tag_len <= tag_len_i;
			end
			if (val_valid_i) begin
				field_o.val <= val_i;
				field_o.val_len <= val_len_i;
			end
		end
	end

	assign field_req_o = tag_seen && val_seen;

endmodule

//--- hw/fix_field_serializer.sv
`timescale 1ns/1ps

module fix_field_serializer (
	input  logic                             clk,
	input  logic                             rst,
	input  fix_pkg::fix_field_t              field_i,
	input  logic                             field_req_i,
	input  logic                             end_req_i,
	input  logic [fix_pkg::DIGITS_W-1:0]     cksum_digits_i,
	output logic                             take_o,
	output logic                             busy_o,
	output fix_pkg::fix_beat_t               beat_o,
	output logic                             beat_valid_o,
	output logic                             body_o
);

	import fix_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_TAG,
		ST_EQ,
		ST_VAL,
		ST_SOH,
		ST_TRAILER
	} state_t;

	state_t state;

	// bytes left in the current section, counts down to 1
	logic [VAL_LEN_W-1:0] cnt;
	logic [TAG_LEN_W-1:0] tag_idx;
	logic [VAL_LEN_W-1:0] val_idx;

	assign tag_idx = field_i.tag_len - cnt[TAG_LEN_W-1:0];
	assign val_idx = field_i.val_len - cnt;

	assign take_o = (state == ST_IDLE) && (field_req_i || end_req_i);
	assign busy_o = (state != ST_IDLE) || field_req_i || end_req_i;

	// ##############################
	// state register
	// ##############################

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			cnt <= '0;
		end else begin
			case (state)
			ST_IDLE: begin
				if (end_req_i) begin
					state <= ST_TRAILER;
					cnt <= VAL_LEN_W'(TRAILER_LEN - 1);
				end else if (field_req_i) begin
					state <= ST_TAG;
					cnt <= {{(VAL_LEN_W-TAG_LEN_W){1'b0}}, field_i.tag_len};
				end
			end
			ST_TAG: begin
				if (cnt == 1)
					state <= ST_EQ;
				cnt <= cnt - 1'b1;
			end
			ST_EQ: begin
				state <= ST_VAL;
				cnt <= field_i.val_len;
			end
			ST_VAL: begin
				if (cnt == 1)
					state <= ST_SOH;
				cnt <= cnt - 1'b1;
			end
			ST_SOH: begin
				state <= ST_IDLE;
			end
			ST_TRAILER: begin
				if (cnt == 0)
					state <= ST_IDLE;
				else
					cnt <= cnt - 1'b1;
			end
			default: begin
				state <= ST_IDLE;
			end
			endcase
		end
	end

	// ##############################
	// beat generation
	// ##############################

	always_comb begin
		beat_o = '0;
		beat_valid_o = 1'b1;
		body_o = 1'b1;
		case (state)
		ST_TAG: beat_o.data = field_i.tag[tag_idx[TAG_IDX_W-1:0]*8 +: 8];
		ST_EQ: beat_o.data = ASCII_EQ;
		ST_VAL: beat_o.data = field_i.val[val_idx[VAL_IDX_W-1:0]*8 +: 8];
		ST_SOH: begin
			beat_o.data = ASCII_SOH;
			beat_o.field_last = 1'b1;
		end
		ST_TRAILER: begin
			body_o = 1'b0;
			case (cnt[2:0])
			3'd6: beat_o.data = CKSUM_TAG0;
			3'd5: beat_o.data = CKSUM_TAG1;
			3'd4: beat_o.data = ASCII_EQ;
			3'd3: beat_o.data = cksum_digits_i[23:16];
			3'd2: beat_o.data = cksum_digits_i[15:8];
			3'd1: beat_o.data = cksum_digits_i[7:0];
			default: begin
				beat_o.data = ASCII_SOH;
				beat_o.msg_last = 1'b1;
			end
			endcase
		end
		default: begin
			beat_valid_o = 1'b0;
			body_o = 1'b0;
		end
		endcase
	end

endmodule

//--- hw/fix_checksum.sv
`timescale 1ns/1ps

module fix_checksum (
	input  logic                          clk,
	input  logic                          rst,
	input  fix_pkg::fix_beat_t            beat_i,
	input  logic                          beat_valid_i,
	input  logic                          body_i,
	output logic [fix_pkg::DIGITS_W-1:0]  cksum_digits_o
);

	import fix_pkg::*;

	logic [7:0] sum;
	logic [7:0] rem;
	logic [7:0] hund;
	logic [7:0] tens;
	logic [7:0] units;
	logic [14:0] tens_prod;

	always_ff @(posedge clk) begin
		if (rst)
			sum <= '0;
		else if (beat_valid_i && beat_i.msg_last)
			sum <= '0;
		else if (beat_valid_i && body_i)
			sum <= sum + beat_i.data;
	end

	// ##############################
	// binary to three decimal digits
	// ##############################

	always_comb begin
		if (sum >= 8'd200) begin
			hund = 8'd2;
			rem = sum - 8'd200;
		end else if (sum >= 8'd100) begin
			hund = 8'd1;
			rem = sum - 8'd100;
		end else begin
			hund = 8'd0;
			rem = sum;
		end
		// rem/10 as rem*205>>11, exact below 100
		tens_prod = rem * 15'd205;
		tens = {4'b0000, tens_prod[14:11]};
		units = rem - tens * 8'd10;
	end

	always_ff @(posedge clk) begin
		cksum_digits_o <= {ASCII_ZERO + hund, ASCII_ZERO + tens, ASCII_ZERO + units};
	end

endmodule

//--- hw/fix_byte_out.sv
`timescale 1ns/1ps

module fix_byte_out (
	input  logic                           clk,
	input  logic                           rst,
	input  fix_pkg::fix_beat_t             beat_i,
	input  logic                           beat_valid_i,
	output logic [7:0]                     data_o,
	output logic                           data_valid_o,
	output logic                           done_o,
	output logic                           end_o,
	output logic [fix_pkg::MSG_LEN_W-1:0]  msg_len_o
);

	// bytes already sent in this message
	logic [fix_pkg::MSG_LEN_W-1:0] len_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			data_valid_o <= 1'b0;
			done_o <= 1'b0;
			end_o <= 1'b0;
			len_cnt <= '0;
		end else begin
			data_valid_o <= beat_valid_i;
			done_o <= beat_valid_i && beat_i.field_last;
			end_o <= beat_valid_i && beat_i.msg_last;
			if (beat_valid_i) begin
				if (beat_i.msg_last)
					len_cnt <= '0;
				else
					len_cnt <= len_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		data_o <= beat_i.data;
		// trailer SOH counts too
		if (beat_valid_i && beat_i.msg_last)
			msg_len_o <= len_cnt + 1'b1;
	end

endmodule

//--- hw/fix_msg_builder.sv
`timescale 1ns/1ps

module fix_msg_builder (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              tag_valid_i,
	input  logic [fix_pkg::TAG_BYTES*8-1:0]   tag_i,
	input  logic [fix_pkg::TAG_LEN_W-1:0]     tag_len_i,
	input  logic                              val_valid_i,
	input  logic [fix_pkg::VAL_BYTES*8-1:0]   val_i,
	input  logic [fix_pkg::VAL_LEN_W-1:0]     val_len_i,
	input  logic                              end_msg_i,
	output logic [7:0]                        data_o,
	output logic                              data_valid_o,
	output logic                              done_o,
	output logic                              end_o,
	output logic [fix_pkg::MSG_LEN_W-1:0]     msg_len_o,
	output logic                              busy_o
);

	import fix_pkg::*;

	fix_field_t field;
	logic field_req;
	logic end_req;
	logic take;

	fix_beat_t beat;
	logic beat_valid;
	logic body;
	logic [DIGITS_W-1:0] cksum_digits;

	fix_field_capture u_capture (
		.clk         (clk),
		.rst         (rst),
		.tag_valid_i (tag_valid_i),
		.tag_i       (tag_i),
		.tag_len_i   (tag_len_i),
		.val_valid_i (val_valid_i),
		.val_i       (val_i),
		.val_len_i   (val_len_i),
		.end_msg_i   (end_msg_i),
		.busy_i      (busy_o),
		.take_i      (take),
		.field_o     (field),
		.field_req_o (field_req),
		.end_req_o   (end_req)
	);

	fix_field_serializer u_serializer (
		.clk            (clk),
		.rst            (rst),
		.field_i        (field),
		.field_req_i    (field_req),
		.end_req_i      (end_req),
		.cksum_digits_i (cksum_digits),
		.take_o         (take),
		.busy_o         (busy_o),
		.beat_o         (beat),
		.beat_valid_o   (beat_valid),
		.body_o         (body)
	);

	fix_checksum u_checksum (
		.clk            (clk),
		.rst            (rst),
		.beat_i         (beat),
		.beat_valid_i   (beat_valid),
		.body_i         (body),
		.cksum_digits_o (cksum_digits)
	);

	fix_byte_out u_byte_out (
		.clk          (clk),
		.rst          (rst),
		.beat_i       (beat),
		.beat_valid_i (beat_valid),
		.data_o       (data_o),
		.data_valid_o (data_valid_o),
		.done_o       (done_o),
		.end_o        (end_o),
		.msg_len_o    (msg_len_o)
	);

endmodule

//--- sim/fix_msg_builder_sva.sv
`timescale 1ns/1ps

module fix_msg_builder_sva (
	input logic       clk,
	input logic       rst,
	input logic [7:0] data_o,
	input logic       data_valid_o,
	input logic       done_o,
	input logic       end_o,
	input logic       busy_o
);

	// ##############################
	// output protocol
	// ##############################

	a_pulse_valid: assert property (@(posedge clk) disable iff (rst)
		(done_o || end_o) |-> data_valid_o)
		else $error("done or end without valid data");

	a_pulse_excl: assert property (@(posedge clk) disable iff (rst)
		!(done_o && end_o))
		else $error("done and end in the same cycle");

	a_pulse_soh: assert property (@(posedge clk) disable iff (rst)
		(done_o || end_o) |-> (data_o == 8'h01))
		else $error("field or message end without SOH");

	a_reset_idle: assert property (@(posedge clk)
		rst |=> (!data_valid_o && !done_o && !end_o && !busy_o))
		else $error("outputs active after reset");

endmodule

bind fix_msg_builder fix_msg_builder_sva u_sva (
	.clk          (clk),
	.rst          (rst),
	.data_o       (data_o),
	.data_valid_o (data_valid_o),
	.done_o       (done_o),
	.end_o        (end_o),
	.busy_o       (busy_o)
);

//--- sim/fix_msg_builder_tb.sv
`timescale 1ns/1ps

module fix_msg_builder_tb;

	import fix_pkg::*;

	localparam int NUM_TESTS = 8;

	logic clk;
	logic rst;
	logic tag_valid_i;
	logic [TAG_BYTES*8-1:0] tag_i;
	logic [TAG_LEN_W-1:0] tag_len_i;
	logic val_valid_i;
	logic [VAL_BYTES*8-1:0] val_i;
	logic [VAL_LEN_W-1:0] val_len_i;
	logic end_msg_i;
	logic [7:0] data_o;
	logic data_valid_o;
	logic done_o;
	logic end_o;
	logic [MSG_LEN_W-1:0] msg_len_o;
	logic busy_o;

	fix_msg_builder dut (.*);

	// ##############################
	// test table
	// ##############################

	// order 0 tag first, 1 value first, 2 same cycle, 3 last field sends its tag only
	string name_tab[NUM_TESTS];
	int nf_tab[NUM_TESTS];
	int tl_tab[NUM_TESTS][3];
	int vl_tab[NUM_TESTS][3];
	int order_tab[NUM_TESTS];
	int gap_tab[NUM_TESTS];
	bit inject_tab[NUM_TESTS];
	bit end_tab[NUM_TESTS];
	bit reset_tab[NUM_TESTS];

	int n_entries = 0;

	task automatic add_entry(string name, int nf, int t0, int t1, int t2, int v0, int v1,
			int v2, int order, int gap, bit inject, bit send_end, bit reset_after);
		name_tab[n_entries] = name;
		nf_tab[n_entries] = nf;
		tl_tab[n_entries] = '{t0, t1, t2};
		vl_tab[n_entries] = '{v0, v1, v2};
		order_tab[n_entries] = order;
		gap_tab[n_entries] = gap;
		inject_tab[n_entries] = inject;
		end_tab[n_entries] = send_end;
		reset_tab[n_entries] = reset_after;
		n_entries++;
	endtask

	function automatic int table_bytes();
		int total;
		total = 0;
		for (int t = 0; t < n_entries; t++) begin
			for (int f = 0; f < nf_tab[t]; f++)
				total += tl_tab[t][f] + vl_tab[t][f] + 2;
			total += TRAILER_LEN + 10;
		end
		return total;
	endfunction

	// ##############################
	// lfsr data and reference model
	// ##############################

	logic [31:0] lfsr = 32'h2b3c;

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	fix_beat_t exp_q[$];
	logic [MSG_LEN_W-1:0] exp_len_q[$];
	logic [7:0] model_sum;
	int model_len;
	string cur_name;

	task automatic model_push(logic [7:0] data, logic fl, logic ml, bit body);
		exp_q.push_back('{data: data, field_last: fl, msg_last: ml});
		if (body)
			model_sum += data;
		model_len++;
	endtask

	task automatic model_trailer();
		int s;
		s = model_sum;
		model_push("1", 0, 0, 0);
		model_push("0", 0, 0, 0);
		model_push("=", 0, 0, 0);
		model_push(8'h30 + s / 100, 0, 0, 0);
		model_push(8'h30 + (s / 10) % 10, 0, 0, 0);
		model_push(8'h30 + s % 10, 0, 0, 0);
		model_push(8'h01, 0, 1, 0);
		exp_len_q.push_back(MSG_LEN_W'(model_len));
		model_sum = 0;
		model_len = 0;
	endtask

	// ##############################
	// checks
	// ##############################

	task automatic fail_run(string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(string what, logic [7:0] exp, logic [7:0] act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s %s: expected %02h, actual %02h", cur_name, what, exp, act));
	endtask

	task automatic check_flag(string what, logic exp, logic act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s %s: expected %0b, actual %0b", cur_name, what, exp, act));
	endtask

	task automatic check_len(logic [MSG_LEN_W-1:0] exp, logic [MSG_LEN_W-1:0] act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s msg_len: expected %0d, actual %0d", cur_name, exp, act));
	endtask

	// monitor, also flags a hole inside a field or trailer
	bit mid_run = 0;
	fix_beat_t exp_beat;

	always @(posedge clk) begin
		if (!rst && data_valid_o) begin
			if (exp_q.size() == 0)
				fail_run($sformatf("%s: DUT sent byte %02h that was not expected", cur_name, data_o));
			exp_beat = exp_q.pop_front();
			check_byte("data", exp_beat.data, data_o);
			check_flag("done", exp_beat.field_last, done_o);
			check_flag("end", exp_beat.msg_last, end_o);
			if (end_o)
				check_len(exp_len_q.pop_front(), msg_len_o);
			mid_run = !(exp_beat.field_last || exp_beat.msg_last);
		end else if (!rst && mid_run) begin
			fail_run($sformatf("%s: output stream paused inside a field", cur_name));
		end
	end

	// ##############################
	// drive
	// ##############################

	task automatic wait_busy_cycle();
		do @(posedge clk); while (!busy_o);
		do @(posedge clk); while (busy_o);
	endtask

	task automatic pulse(bit tag, bit val, bit endm);
		@(posedge clk);
		tag_valid_i <= tag;
		val_valid_i <= val;
		end_msg_i <= endm;
		@(posedge clk);
		tag_valid_i <= 1'b0;
		val_valid_i <= 1'b0;
		end_msg_i <= 1'b0;
	endtask

	task automatic load_data(int tl, int vl);
		logic [VAL_BYTES*8-1:0] v;
		for (int i = 0; i < VAL_BYTES / 4; i++)
			v[i*32 +: 32] = rand_bits(32);
		tag_i <= rand_bits(32);
		tag_len_i <= TAG_LEN_W'(tl);
		val_i <= v;
		val_len_i <= VAL_LEN_W'(vl);
	endtask

	task automatic send_field(int t, int f);
		int tl;
		int vl;
		bit tag_only;
		tl = tl_tab[t][f];
		vl = vl_tab[t][f];
		tag_only = (order_tab[t] == 3) && (f == nf_tab[t] - 1);
		@(posedge clk);
		load_data(tl, vl);
		if (order_tab[t] == 2) begin
			pulse(1, 1, 0);
		end else begin
			pulse(order_tab[t] != 1, order_tab[t] == 1, 0);
			repeat (gap_tab[t]) @(posedge clk);
			if (!tag_only)
				pulse(order_tab[t] == 1, order_tab[t] != 1, 0);
		end
		if (tag_only)
			return;
		for (int i = 0; i < tl; i++)
			model_push(tag_i[i*8 +: 8], 0, 0, 1);
		model_push(ASCII_EQ, 0, 0, 1);
		for (int i = 0; i < vl; i++)
			model_push(val_i[i*8 +: 8], 0, 0, 1);
		model_push(ASCII_SOH, 1, 0, 1);
		do @(posedge clk); while (!busy_o);
		if (inject_tab[t]) begin
			// a complete field offered while busy, must vanish
			load_data(3, 3);
			pulse(1, 1, 0);
		end
		do @(posedge clk); while (busy_o);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_flag("data_valid after reset", 0, data_valid_o);
		check_flag("done after reset", 0, done_o);
		check_flag("end after reset", 0, end_o);
		check_flag("busy after reset", 0, busy_o);
		model_sum = 0;
		model_len = 0;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#1;
		repeat (table_bytes() * 40) @(posedge clk);
		fail_run($sformatf("%s: watchdog expired, the DUT appears to hang", cur_name));
	end

	initial begin
		rst = 1'b1;
		tag_valid_i = 1'b0;
		tag_i = '0;
		tag_len_i = '0;
		val_valid_i = 1'b0;
		val_i = '0;
		val_len_i = '0;
		end_msg_i = 1'b0;
		model_sum = 0;
		model_len = 0;
		cur_name = "reset";
		add_entry("single_field", 1, 2, 0, 0, 5, 0, 0, 0, 0, 0, 1, 0);
		add_entry("multi_field", 3, 1, 4, 3, 1, 32, 7, 0, 0, 0, 1, 0);
		add_entry("value_first_gap", 2, 3, 2, 0, 4, 6, 0, 1, 3, 0, 1, 0);
		add_entry("same_cycle", 2, 3, 2, 0, 4, 6, 0, 2, 0, 0, 1, 0);
		add_entry("busy_inject", 2, 4, 1, 0, 10, 2, 0, 0, 1, 1, 1, 0);
		add_entry("half_then_end", 3, 2, 3, 1, 3, 3, 2, 3, 0, 0, 1, 0);
		add_entry("no_end_reset", 2, 2, 2, 0, 8, 8, 0, 1, 0, 0, 0, 1);
		add_entry("after_reset", 1, 4, 0, 0, 20, 0, 0, 0, 1, 0, 1, 0);
		apply_reset();
		for (int t = 0; t < n_entries; t++) begin
			cur_name = name_tab[t];
			for (int f = 0; f < nf_tab[t]; f++)
				send_field(t, f);
			if (end_tab[t]) begin
				pulse(0, 0, 1);
				model_trailer();
				wait_busy_cycle();
			end
			while (exp_q.size() > 0)
				@(posedge clk);
			if (reset_tab[t])
				apply_reset();
		end
		repeat (3) @(posedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- vlog.f
hw/fix_pkg.sv
hw/fix_field_capture.sv
hw/fix_field_serializer.sv
hw/fix_checksum.sv
hw/fix_byte_out.sv
hw/fix_msg_builder.sv
sim/fix_msg_builder_sva.sv
sim/fix_msg_builder_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module fix_msg_builder_tb -o fix_msg_builder_sim &&
./obj_dir/fix_msg_builder_sim || exit 1
